// File: design/bank_load_counter.sv
// ======================================
// Bank load counter, stage two. Counts
// requests per bank, then picks the bank
// with the most load as critical bank
// ======================================
`timescale 1ns/1ps
`default_nettype none

module bank_load_counter
    import dram_addr_pkg::*;
    import sched_pkg::*;
#(
    parameter int MAX_REQUESTS = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load,
    input  req_id_t    count,
    output req_id_t    rd_idx,
    input  dram_req_t  rd_req,
    output logic       load_done,
    output bank_id_t   critical_bank,
    output bank_mask_t bank_mask
);

    localparam int CNT_W = $clog2(MAX_REQUESTS + 1);

    typedef enum logic [1:0] {
        LC_IDLE,
        LC_COUNT,
        LC_SCAN,
        LC_DONE
    } lc_state_t;

    lc_state_t        state;
    logic [CNT_W-1:0] bank_cnt [NUM_BANKS];
    logic [CNT_W-1:0] best_cnt;
    bank_id_t         scan_bank;
    bank_id_t         req_bank;

    assign req_bank  = to_bank_id(rd_req);
    assign load_done = (state == LC_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= LC_IDLE;
            rd_idx        <= '0;
            best_cnt      <= '0;
            scan_bank     <= '0;
            critical_bank <= '0;
            bank_mask     <= '0;
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_cnt[b] <= '0;
            end
        end else begin
            case (state)
                LC_IDLE: begin
                    if (load) begin
                        rd_idx        <= '0;
                        best_cnt      <= '0;
                        scan_bank     <= '0;
                        critical_bank <= '0;
                        bank_mask     <= '0;
                        for (int b = 0; b < NUM_BANKS; b++) begin
                            bank_cnt[b] <= '0;
                        end
                        state <= LC_COUNT;
                    end
                end
                // ======================================
                // One buffer entry per cycle
                // ======================================
                LC_COUNT: begin
                    if (rd_idx < count) begin
                        bank_cnt[req_bank] <= bank_cnt[req_bank] + 1'b1;
                    end
                    if (int'(rd_idx) + 1 >= int'(count)) begin
                        state <= LC_SCAN;
                    end else begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                end
                // ======================================
                // One bank per cycle, strict maximum
                // ======================================
                LC_SCAN: begin
                    // Ties keep the earlier, lower bank id
                    if (bank_cnt[scan_bank] > best_cnt) begin
                        best_cnt      <= bank_cnt[scan_bank];
                        critical_bank <= scan_bank;
                    end
                    bank_mask[scan_bank] <= (bank_cnt[scan_bank] != '0);
                    if (scan_bank == bank_id_t'(NUM_BANKS - 1)) begin
                        state <= LC_DONE;
                    end else begin
                        scan_bank <= scan_bank + 1'b1;
                    end
                end
                default: begin
                    state <= LC_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/command_generator.sv
// ======================================
// Command generator, stage three. Walks
// banks critical first, groups requests
// by row and emits PRE, ACT and RD
// ======================================
`timescale 1ns/1ps
`default_nettype none

module command_generator
    import dram_addr_pkg::*;
    import sched_pkg::*;
#(
    parameter int MAX_REQUESTS = 16
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start,
    input  req_id_t      count,
    input  bank_id_t     critical_bank,
    input  bank_mask_t   bank_mask,
    output req_id_t      rd_idx,
    input  dram_req_t    rd_req,
    output logic         wr_en,
    output sched_entry_t wr_entry,
    output slot_t        length,
    output logic         gen_done
);

    localparam int IDX_W = (MAX_REQUESTS > 1) ? $clog2(MAX_REQUESTS) : 1;
    localparam int PTR_W = $clog2(NUM_BANKS) + 1;

    typedef enum logic [2:0] {
        G_IDLE,
        G_FIND,
        G_PRE,
        G_ACT,
        G_RD,
        G_NEXT,
        G_DONE
    } gen_state_t;

    gen_state_t              state;
    logic [MAX_REQUESTS-1:0] req_done;
    logic [NUM_BANKS-1:0]    open_valid;
    row_t                    open_row [NUM_BANKS];
    bank_id_t                cur_bank;
    logic [PTR_W-1:0]        bank_ptr;
    dram_req_t               grp_req;
    req_id_t                 grp_id;
    dram_req_t               pre_req;
    logic                    bank_hit;
    logic                    row_hit;
    logic                    last_idx;

    // Unscheduled request to the current bank
    assign bank_hit = (rd_idx < count) && !req_done[rd_idx[IDX_W-1:0]]
                      && (to_bank_id(rd_req) == cur_bank);
    assign row_hit  = bank_hit && (rd_req.row == grp_req.row);
    assign last_idx = (int'(rd_idx) + 1 >= int'(count));
    assign gen_done = (state == G_DONE);

    // PRE names the row it closes
    always_comb begin
        pre_req     = grp_req;
        pre_req.row = open_row[cur_bank];
    end

    always_comb begin
        wr_en    = 1'b0;
        wr_entry = '0;
        case (state)
            G_PRE: begin
                wr_en        = 1'b1;
                wr_entry.cmd = CMD_PRE;
                wr_entry.req = pre_req;
                wr_entry.id  = grp_id;
            end
            G_ACT: begin
                wr_en        = 1'b1;
                wr_entry.cmd = CMD_ACT;
                wr_entry.req = grp_req;
                wr_entry.id  = grp_id;
            end
            G_RD: begin
                wr_en        = row_hit;
                wr_entry.cmd = CMD_RD;
                wr_entry.req = rd_req;
                wr_entry.id  = rd_idx;
            end
            default: begin
                wr_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= G_IDLE;
            req_done   <= '0;
            open_valid <= '0;
            cur_bank   <= '0;
            bank_ptr   <= '0;
            rd_idx     <= '0;
            grp_id     <= '0;
            length     <= '0;
        end else begin
            if (wr_en) begin
                length <= length + 1'b1;
            end
            case (state)
                G_IDLE: begin
                    if (start) begin
                        req_done   <= '0;
                        open_valid <= '0;
                        length     <= '0;
                        rd_idx     <= '0;
                        bank_ptr   <= '0;
                        cur_bank   <= critical_bank;
                        // Empty critical bank means an empty batch
                        state <= bank_mask[critical_bank] ? G_FIND : G_DONE;
                    end
                end
                // ======================================
                // Earliest unscheduled request in bank
                // ======================================
                G_FIND: begin
                    if (bank_hit) begin
                        grp_id <= rd_idx;
                        if (open_valid[cur_bank] && open_row[cur_bank] != rd_req.row) begin
                            state <= G_PRE;
                        end else begin
                            state <= G_ACT;
                        end
                    end else if (last_idx) begin
                        state <= G_NEXT;
                    end else begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                end
                G_PRE: begin
                    open_valid[cur_bank] <= 1'b0;
                    state                <= G_ACT;
                end
                G_ACT: begin
                    open_valid[cur_bank] <= 1'b1;
                    state                <= G_RD;
                end
                // One RD per matching request, arrival order
                G_RD: begin
                    if (row_hit) begin
                        req_done[rd_idx[IDX_W-1:0]] <= 1'b1;
                    end
                    if (last_idx) begin
                        // Nothing earlier in this bank is left
                        rd_idx <= grp_id;
                        state  <= G_FIND;
                    end else begin
                        rd_idx <= rd_idx + 1'b1;
                    end
                end
                // ======================================
                // Remaining banks in ascending id
                // ======================================
                G_NEXT: begin
                    rd_idx <= '0;
                    if (bank_ptr == PTR_W'(NUM_BANKS)) begin
                        state <= G_DONE;
                    end else begin
                        bank_ptr <= bank_ptr + 1'b1;
                        if (bank_mask[bank_ptr[PTR_W-2:0]]
                            && bank_ptr[PTR_W-2:0] != critical_bank) begin
                            cur_bank <= bank_ptr[PTR_W-2:0];
                            state    <= G_FIND;
                        end
                    end
                end
                default: begin
                    state <= G_IDLE;
                end
            endcase
        end
    end

    // Row group head and open-row table
    always_ff @(posedge clk) begin
        if (state == G_FIND && bank_hit) begin
            grp_req <= rd_req;
        end
        if (state == G_ACT) begin
            open_row[cur_bank] <= grp_req.row;
        end
    end

endmodule

`default_nettype wire

// File: design/dram_addr_pkg.sv
// ======================================
// DRAM address fields, flat bank id and
// command encoding shared by all stages.
// Import with dram_addr_pkg::* where used
// ======================================
`default_nettype none

package dram_addr_pkg;

    typedef logic [1:0]  bank_group_t;
    typedef logic [1:0]  bank_t;
    typedef logic [13:0] row_t;
    typedef logic [9:0]  column_t;

    // Flat bank number, bank group in the upper bits
    typedef logic [3:0]  bank_id_t;

    localparam int NUM_BANKS = 16;

    typedef enum logic [1:0] {
        CMD_NOP,
        CMD_ACT,
        CMD_RD,
        CMD_PRE
    } cmd_t;

    typedef struct packed {
        bank_group_t bank_group;
        bank_t       bank;
        row_t        row;
        column_t     column;
    } dram_req_t;

    function automatic bank_id_t to_bank_id(input dram_req_t r);
        return {r.bank_group, r.bank};
    endfunction

endpackage

`default_nettype wire

// File: design/dram_scheduler_top.sv
// ======================================
// DRAM read scheduler top. Phase control
// and wiring of buffer, load counter,
// command generator and schedule memory
// ======================================
`timescale 1ns/1ps
`default_nettype none

module dram_scheduler_top
    import dram_addr_pkg::*;
    import sched_pkg::*;
#(
    parameter int MAX_REQUESTS = 16,
    parameter int SCHED_SLOTS  = 48
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req_valid,
    input  dram_req_t    req,
    output logic         req_ready,
    input  logic         schedule_start,
    output logic         schedule_busy,
    output logic         schedule_done,
    input  logic         sched_rd_en,
    input  slot_t        sched_rd_slot,
    output sched_entry_t sched_entry,
    output slot_t        sched_length,
    output req_id_t      num_requests,
    output bank_id_t     critical_bank
);

    sched_phase_t phase;
    logic         accept_en;
    logic         start_pulse;
    logic         buf_clear;
    logic         load_done;
    logic         gen_done;
    req_id_t      load_idx;
    req_id_t      gen_idx;
    dram_req_t    load_req;
    dram_req_t    gen_req;
    bank_mask_t   bank_mask;
    logic         wr_en;
    sched_entry_t wr_entry;

    // ======================================
    // Phase control
    // ======================================
    assign accept_en     = (phase == PH_IDLE);
    assign start_pulse   = schedule_start && accept_en;
    assign buf_clear     = (phase == PH_DONE);
    assign schedule_busy = (phase == PH_LOAD) || (phase == PH_GEN);
    assign schedule_done = (phase == PH_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
        end else begin
            case (phase)
                PH_IDLE: if (start_pulse) phase <= PH_LOAD;
                PH_LOAD: if (load_done)   phase <= PH_GEN;
                PH_GEN:  if (gen_done)    phase <= PH_DONE;
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // ======================================
    // Pipeline stages
    // ======================================
    request_buffer #(
        .MAX_REQUESTS (MAX_REQUESTS)
    ) u_request_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .accept_en (accept_en),
        .clear     (buf_clear),
        .count     (num_requests),
        .load_idx  (load_idx),
        .load_req  (load_req),
        .gen_idx   (gen_idx),
        .gen_req   (gen_req)
    );

    bank_load_counter #(
        .MAX_REQUESTS (MAX_REQUESTS)
    ) u_bank_load_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (start_pulse),
        .count         (num_requests),
        .rd_idx        (load_idx),
        .rd_req        (load_req),
        .load_done     (load_done),
        .critical_bank (critical_bank),
        .bank_mask     (bank_mask)
    );

    command_generator #(
        .MAX_REQUESTS (MAX_REQUESTS)
    ) u_command_generator (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (load_done),
        .count         (num_requests),
        .critical_bank (critical_bank),
        .bank_mask     (bank_mask),
        .rd_idx        (gen_idx),
        .rd_req        (gen_req),
        .wr_en         (wr_en),
        .wr_entry      (wr_entry),
        .length        (sched_length),
        .gen_done      (gen_done)
    );

    // Slot of each write is the length before it
    schedule_memory #(
        .SCHED_SLOTS (SCHED_SLOTS)
    ) u_schedule_memory (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (start_pulse),
        .wr_en    (wr_en),
        .wr_slot  (sched_length),
        .wr_entry (wr_entry),
        .rd_en    (sched_rd_en),
        .rd_slot  (sched_rd_slot),
        .rd_entry (sched_entry)
    );

endmodule

`default_nettype wire

// File: design/request_buffer.sv
// ======================================
// Request buffer, stage one. Stores the
// batch in arrival order and serves the
// load counter and the generator
// ======================================
`timescale 1ns/1ps
`default_nettype none

module request_buffer
    import dram_addr_pkg::*;
    import sched_pkg::*;
#(
    parameter int MAX_REQUESTS = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  dram_req_t req,
    output logic      req_ready,
    input  logic      accept_en,
    input  logic      clear,
    output req_id_t   count,
    input  req_id_t   load_idx,
    output dram_req_t load_req,
    input  req_id_t   gen_idx,
    output dram_req_t gen_req
);

    localparam int IDX_W = (MAX_REQUESTS > 1) ? $clog2(MAX_REQUESTS) : 1;

    dram_req_t mem [MAX_REQUESTS];
    logic      full;
    logic      push;

    assign full      = (count >= req_id_t'(MAX_REQUESTS));
    assign req_ready = accept_en && !full;
    assign push      = req_valid && req_ready;

    // Two independent read ports
    assign load_req = mem[load_idx[IDX_W-1:0]];
    assign gen_req  = mem[gen_idx[IDX_W-1:0]];

    // Count doubles as the write pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (push) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[count[IDX_W-1:0]] <= req;
        end
    end

endmodule

`default_nettype wire

// File: design/sched_pkg.sv
// ======================================
// Scheduler-side ids, slot numbers and
// the schedule entry layout
// ======================================
`default_nettype none

package sched_pkg;

    import dram_addr_pkg::*;

    // Request index and request count
    typedef logic [7:0]           req_id_t;
    typedef logic [7:0]           slot_t;
    typedef logic [NUM_BANKS-1:0] bank_mask_t;

    // PRE and ACT carry the request that caused them
    typedef struct packed {
        cmd_t      cmd;
        dram_req_t req;
        req_id_t   id;
    } sched_entry_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_LOAD,
        PH_GEN,
        PH_DONE
    } sched_phase_t;

endpackage

`default_nettype wire

// File: design/schedule_memory.sv
// ======================================
// Schedule memory, stage four. One entry
// per slot, registered readback by slot
// ======================================
`timescale 1ns/1ps
`default_nettype none

module schedule_memory
    import sched_pkg::*;
#(
    parameter int SCHED_SLOTS = 48
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         clear,
    input  logic         wr_en,
    input  slot_t        wr_slot,
    input  sched_entry_t wr_entry,
    input  logic         rd_en,
    input  slot_t        rd_slot,
    output sched_entry_t rd_entry
);

    localparam int SLOT_W = (SCHED_SLOTS > 1) ? $clog2(SCHED_SLOTS) : 1;

    sched_entry_t mem [SCHED_SLOTS];
    logic         wr_ok;
    logic         rd_ok;

    assign wr_ok = wr_en && (int'(wr_slot) < SCHED_SLOTS);
    assign rd_ok = (int'(rd_slot) < SCHED_SLOTS);

    always_ff @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < SCHED_SLOTS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_ok) begin
            mem[wr_slot[SLOT_W-1:0]] <= wr_entry;
        end
    end

    // Slots past the end read as NOP
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_entry <= '0;
        end else if (rd_en) begin
            rd_entry <= rd_ok ? mem[rd_slot[SLOT_W-1:0]] : '0;
        end
    end

endmodule

`default_nettype wire

// File: dram_scheduler.f
+incdir+testbench
design/dram_addr_pkg.sv
design/sched_pkg.sv
design/request_buffer.sv
design/bank_load_counter.sv
design/command_generator.sv
design/schedule_memory.sv
design/dram_scheduler_top.sv
testbench/tb_dram_scheduler.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the DRAM scheduler testbench with Verilator and run it.
# Pass or fail is taken from the simulation output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f dram_scheduler.f --top-module tb_dram_scheduler; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_output="$(./obj_dir/Vtb_dram_scheduler 2>&1)"; then
    echo "$sim_output"
    echo "Simulation exited with an error status"
    exit 1
fi

echo "$sim_output"

if echo "$sim_output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

// File: testbench/tb_sched_model.svh
// ========================================
// Reference model for the scheduler test.
// Computes the critical bank and the
// expected PRE/ACT/RD list from the sent
// requests. Included inside the testbench
// ========================================
`ifndef TB_SCHED_MODEL_SVH
`define TB_SCHED_MODEL_SVH

// Flat bank number, bank group above bank
function automatic bank_id_t bank_of_req(input dram_req_t r);
    return {r.bank_group, r.bank};
endfunction

function automatic int requests_in_bank(input dram_req_t reqs[$], input bank_id_t b);
    int n;
    n = 0;
    foreach (reqs[i]) begin
        if (bank_of_req(reqs[i]) == b) begin
            n++;
        end
    end
    return n;
endfunction

// Most loaded bank, lowest id on a tie
function automatic bank_id_t ref_critical_bank(input dram_req_t reqs[$]);
    bank_id_t best_bank;
    int       best_load;
    int       cur_load;
    best_bank = '0;
    best_load = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
        cur_load = requests_in_bank(reqs, bank_id_t'(b));
        if (cur_load > best_load) begin
            best_load = cur_load;
            best_bank = bank_id_t'(b);
        end
    end
    return best_bank;
endfunction

// ========================================
// Expected schedule, returns its length
// ========================================
function automatic slot_t ref_schedule(input dram_req_t reqs[$],
                                       output sched_entry_t exp_q[$]);
    bank_id_t     crit;
    bank_id_t     order[$];
    bank_id_t     b;
    bit           taken [256];
    bit           row_open [NUM_BANKS];
    row_t         open_rows [NUM_BANKS];
    row_t         grp_row;
    sched_entry_t e;
    int           head;
    exp_q = {};
    crit  = ref_critical_bank(reqs);
    for (int i = 0; i < 256; i++) begin
        taken[i] = 1'b0;
    end
    for (int k = 0; k < NUM_BANKS; k++) begin
        row_open[k]  = 1'b0;
        open_rows[k] = '0;
    end
    // Critical bank first, then the rest in ascending id
    if (requests_in_bank(reqs, crit) > 0) begin
        order.push_back(crit);
    end
    for (int k = 0; k < NUM_BANKS; k++) begin
        if (bank_id_t'(k) != crit && requests_in_bank(reqs, bank_id_t'(k)) > 0) begin
            order.push_back(bank_id_t'(k));
        end
    end
    foreach (order[n]) begin
        b    = order[n];
        head = 0;
        while (head >= 0) begin
            // Earliest request of this bank not yet served
            head = -1;
            for (int i = reqs.size() - 1; i >= 0; i--) begin
                if (!taken[i] && bank_of_req(reqs[i]) == b) begin
                    head = i;
                end
            end
            if (head >= 0) begin
                grp_row = reqs[head].row;
                if (row_open[b] && open_rows[b] != grp_row) begin
                    e.cmd     = CMD_PRE;
                    e.req     = reqs[head];
                    e.req.row = open_rows[b];
                    e.id      = req_id_t'(head);
                    exp_q.push_back(e);
                end
                e.cmd = CMD_ACT;
                e.req = reqs[head];
                e.id  = req_id_t'(head);
                exp_q.push_back(e);
                row_open[b]  = 1'b1;
                open_rows[b] = grp_row;
                for (int j = head; j < reqs.size(); j++) begin
                    if (!taken[j] && bank_of_req(reqs[j]) == b && reqs[j].row == grp_row) begin
                        e.cmd    = CMD_RD;
                        e.req    = reqs[j];
                        e.id     = req_id_t'(j);
                        taken[j] = 1'b1;
                        exp_q.push_back(e);
                    end
                end
            end
        end
    end
    return slot_t'(exp_q.size());
endfunction

`endif

// File: testbench/tb_dram_scheduler.sv
// ========================================
// Testbench for the DRAM read scheduler.
// Sends request batches, waits for done and
// compares critical bank and every slot
// against the reference model
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tb_dram_scheduler
    import dram_addr_pkg::*;
    import sched_pkg::*;
();

    localparam int          TB_MAX_REQUESTS = 16;
    localparam int          TB_SCHED_SLOTS  = 48;
    localparam int          DONE_TIMEOUT    = 5000;
    localparam logic [31:0] TB_SEED         = 32'h92ea_20e3;
    localparam row_t        ROW_A           = 14'h0123;
    localparam row_t        ROW_B           = 14'h0456;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    dram_req_t    req;
    logic         req_ready;
    logic         schedule_start;
    logic         schedule_busy;
    logic         schedule_done;
    logic         sched_rd_en;
    slot_t        sched_rd_slot;
    sched_entry_t sched_entry;
    slot_t        sched_length;
    req_id_t      num_requests;
    bank_id_t     critical_bank;

    dram_req_t    sent_q[$];
    dram_req_t    next_req;
    int unsigned  seed_dummy;

    dram_scheduler_top #(
        .MAX_REQUESTS (TB_MAX_REQUESTS),
        .SCHED_SLOTS  (TB_SCHED_SLOTS)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .schedule_start (schedule_start),
        .schedule_busy  (schedule_busy),
        .schedule_done  (schedule_done),
        .sched_rd_en    (sched_rd_en),
        .sched_rd_slot  (sched_rd_slot),
        .sched_entry    (sched_entry),
        .sched_length   (sched_length),
        .num_requests   (num_requests),
        .critical_bank  (critical_bank)
    );

    always #20 clk = ~clk;

    `include "tb_sched_model.svh"

    // ========================================
    // Failure handling and compare tasks
    // ========================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_id(input string name, input req_id_t exp, input req_id_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bank(input string name, input bank_id_t exp, input bank_id_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_slot(input string name, input slot_t exp, input slot_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_entry(input string name, input sched_entry_t exp,
                               input sched_entry_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Few banks and rows, so groups and PREs show up
    function automatic dram_req_t make_random_req();
        dram_req_t r;
        r.bank_group = bank_group_t'($urandom_range(0, 1));
        r.bank       = bank_t'($urandom_range(0, 3));
        r.row        = row_t'(32'h0100 + $urandom_range(0, 2));
        r.column     = column_t'($urandom());
        return r;
    endfunction

    function automatic dram_req_t make_req(input bank_group_t bg, input bank_t bk,
                                           input row_t row, input column_t col);
        dram_req_t r;
        r.bank_group = bg;
        r.bank       = bk;
        r.row        = row;
        r.column     = col;
        return r;
    endfunction

    // Offer one request for one cycle, keep it if taken
    task automatic send_request(input string name, input dram_req_t r,
                                input logic expect_ready);
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
        if (req_ready !== expect_ready) begin
            abort_run($sformatf("ERROR %s req_ready at request %0d expected %b actual %b",
                                name, sent_q.size(), expect_ready, req_ready));
        end
        if (req_ready === 1'b1) begin
            sent_q.push_back(r);
        end
    endtask

    // ========================================
    // Start, wait for done, compare results
    // ========================================
    task automatic run_batch(input string name);
        sched_entry_t exp_q[$];
        slot_t        exp_len;
        bank_id_t     exp_crit;
        int           cycles;
        bit           saw_busy;
        exp_len  = ref_schedule(sent_q, exp_q);
        exp_crit = ref_critical_bank(sent_q);
        cycles   = 0;
        saw_busy = 1'b0;
        @(negedge clk);
        req_valid      = 1'b0;
        schedule_start = 1'b1;
        @(negedge clk);
        schedule_start = 1'b0;
        // Offered while busy, must be refused
        req_valid = 1'b1;
        req       = make_random_req();
        while (schedule_done !== 1'b1) begin
            if (schedule_busy === 1'b1) begin
                saw_busy = 1'b1;
                if (req_ready !== 1'b0) begin
                    abort_run($sformatf("ERROR %s req_ready while busy expected 0 actual %b",
                                        name, req_ready));
                end
            end
            if (cycles >= DONE_TIMEOUT) begin
                abort_run($sformatf("%s: timed out waiting for schedule_done", name));
            end
            @(negedge clk);
            cycles++;
        end
        req_valid = 1'b0;
        if (!saw_busy) begin
            abort_run($sformatf("%s: schedule_busy never went high", name));
        end
        check_bank({name, " critical_bank"}, exp_crit, critical_bank);
        check_slot({name, " sched_length"}, exp_len, sched_length);
        @(negedge clk);
        check_id({name, " num_requests after done"}, '0, num_requests);
        // One slot past the end must read back empty
        for (int s = 0; s <= int'(exp_len) && s < TB_SCHED_SLOTS; s++) begin
            sched_rd_en   = 1'b1;
            sched_rd_slot = slot_t'(s);
            @(negedge clk);
            sched_rd_en = 1'b0;
            if (s < int'(exp_len)) begin
                check_entry($sformatf("%s slot %0d", name, s), exp_q[s], sched_entry);
            end else begin
                check_entry($sformatf("%s slot %0d past end", name, s), '0, sched_entry);
            end
        end
        sent_q.delete();
    endtask

    initial begin
        seed_dummy     = $urandom(TB_SEED);
        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        schedule_start = 1'b0;
        sched_rd_en    = 1'b0;
        sched_rd_slot  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        if (req_ready !== 1'b1) begin
            abort_run($sformatf("ERROR reset req_ready expected 1 actual %b", req_ready));
        end
        if (schedule_busy !== 1'b0) begin
            abort_run($sformatf("ERROR reset schedule_busy expected 0 actual %b",
                                schedule_busy));
        end
        if (schedule_done !== 1'b0) begin
            abort_run($sformatf("ERROR reset schedule_done expected 0 actual %b",
                                schedule_done));
        end
        check_id("reset num_requests", '0, num_requests);
        check_slot("reset sched_length", '0, sched_length);
        check_bank("reset critical_bank", '0, critical_bank);

        // Fill past capacity, the last three are refused
        for (int i = 0; i < TB_MAX_REQUESTS + 3; i++) begin
            next_req = make_random_req();
            send_request("fill", next_req, (i < TB_MAX_REQUESTS));
        end
        @(negedge clk);
        req_valid = 1'b0;
        check_id("fill num_requests", req_id_t'(TB_MAX_REQUESTS), num_requests);
        run_batch("random_full");

        // Banks 5 and 2 tie on two requests each
        send_request("tie", make_req(2'd2, 2'd1, 14'h0010, 10'h001), 1'b1);
        send_request("tie", make_req(2'd1, 2'd1, 14'h0020, 10'h002), 1'b1);
        send_request("tie", make_req(2'd0, 2'd2, 14'h0030, 10'h003), 1'b1);
        send_request("tie", make_req(2'd1, 2'd1, 14'h0040, 10'h004), 1'b1);
        send_request("tie", make_req(2'd0, 2'd2, 14'h0030, 10'h005), 1'b1);
        run_batch("tie");
        check_bank("tie lowest bank id", 4'd2, critical_bank);

        // Rows A, B, A in one bank
        send_request("row_group", make_req(2'd1, 2'd2, ROW_A, 10'h011), 1'b1);
        send_request("row_group", make_req(2'd1, 2'd2, ROW_B, 10'h022), 1'b1);
        send_request("row_group", make_req(2'd1, 2'd2, ROW_A, 10'h033), 1'b1);
        run_batch("row_group");
        check_slot("row_group length", 8'd6, sched_length);

        for (int i = 0; i < 11; i++) begin
            next_req = make_random_req();
            send_request("second", next_req, 1'b1);
        end
        run_batch("random_second");

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
